// File: Makefile
SIM   ?= verilator
FLAGS ?= --binary --timing --assert
TOP   ?= tb_inst_window
FLIST ?= list.f
MDIR  ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run the testbench"
	@echo "  clean  remove build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(MDIR) -o $(TOP)
	./$(MDIR)/$(TOP) | tee /dev/stderr | grep -q "Finished with no errors"

clean:
	rm -rf $(MDIR)

// File: design/dispatch_unpack.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_unpack
    import isa_pkg::*;
    import iw_pkg::*;
(
    input  dec_info_t d_info,
    output slot_t     entry
);

    always_comb begin
        // a decode without any exec bit becomes an empty slot
        entry.valid = (d_info.exec != EXEC_NOP);
        entry.exec  = d_info.exec;
        entry.func3 = d_info.func3;
        entry.func7 = d_info.func7;
        entry.imm   = d_info.imm;

        entry.va_rs1 = d_info.va_rs1;
        entry.va_rs2 = d_info.va_rs2;
        entry.va_rd  = d_info.va_rd;

        // operands nobody asked for are ready from the start
        entry.rs1_ready = ~d_info.rs1_req;
        entry.rs2_ready = ~d_info.rs2_req;
        entry.rd_ready  = ~d_info.rd_req;

        entry.d_rs1 = '0;
        // immediate alu ops carry imm as second operand
        if (d_info.exec[EXEC_ALU_IMM]) begin
            entry.d_rs2 = d_info.imm;
        end else begin
            entry.d_rs2 = '0;
        end
        // filled in by the register reply when rd is requested
        entry.pa_rd = '0;

        entry.ctx     = d_info.ctx;
        entry.b_t_ctx = d_info.b_t_ctx;
        entry.b_f_ctx = d_info.b_f_ctx;
    end

endmodule

`default_nettype wire

// File: design/inst_window.sv
`timescale 1ns/1ps
`default_nettype none

module inst_window
    import iw_pkg::*;
#(
    parameter int WIN_SIZE   = 8,
    parameter int ISSUE_SPAN = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        d_done,
    input  dec_info_t   d_info,
    output logic        accept_able,
    output logic        lookup_valid,
    output reg_lookup_t lookup,
    input  logic        reply_valid,
    input  reg_reply_t  reply,
    output logic        order,
    output issue_t      issue,
    input  logic        accepted,
    input  logic        branch_hazard,
    input  ctx_t        hazard_ctx
);

    slot_t entry;
    slot_t slots        [WIN_SIZE];
    slot_t kept_slots   [WIN_SIZE];
    slot_t packed_slots [WIN_SIZE];
    slot_t next_slots   [WIN_SIZE];

    dispatch_unpack dispatch_unpack_i (
        .d_info (d_info),
        .entry  (entry)
    );

    window_slots #(.WIN_SIZE(WIN_SIZE)) window_slots_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .next_slots  (next_slots),
        .entry       (entry),
        .d_done      (d_done),
        .accept_able (accept_able),
        .slots       (slots)
    );

    issue_select #(.WIN_SIZE(WIN_SIZE), .ISSUE_SPAN(ISSUE_SPAN)) issue_select_i (
        .slots      (slots),
        .accepted   (accepted),
        .order      (order),
        .issue      (issue),
        .kept_slots (kept_slots)
    );

    window_compact #(.WIN_SIZE(WIN_SIZE)) window_compact_i (
        .kept_slots   (kept_slots),
        .packed_slots (packed_slots),
        .accept_able  (accept_able)
    );

    operand_resolve #(.WIN_SIZE(WIN_SIZE)) operand_resolve_i (
        .slots         (slots),
        .packed_slots  (packed_slots),
        .reply_valid   (reply_valid),
        .reply         (reply),
        .branch_hazard (branch_hazard),
        .hazard_ctx    (hazard_ctx),
        .lookup_valid  (lookup_valid),
        .lookup        (lookup),
        .next_slots    (next_slots)
    );

endmodule

`default_nettype wire

// File: design/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // data path width
    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [2:0]        func3_t;
    typedef logic [6:0]        func7_t;

    // one-hot exec type, one bit per unit class
    localparam int EXEC_W = 4;

    typedef logic [EXEC_W-1:0] exec_t;

    localparam int EXEC_ALU_REG = 0;
    localparam int EXEC_ALU_IMM = 1;
    localparam int EXEC_MEM     = 2;
    localparam int EXEC_JUMP    = 3;

    // all bits clear marks an empty decode
    localparam exec_t EXEC_NOP = '0;

endpackage

`default_nettype wire

// File: design/issue_select.sv
`timescale 1ns/1ps
`default_nettype none

module issue_select
    import iw_pkg::*;
#(
    parameter int WIN_SIZE   = 8,
    parameter int ISSUE_SPAN = 4
) (
    input  slot_t  slots      [WIN_SIZE],
    input  logic   accepted,
    output logic   order,
    output issue_t issue,
    output slot_t  kept_slots [WIN_SIZE]
);

    localparam int SEL_W = (ISSUE_SPAN > 1) ? $clog2(ISSUE_SPAN) : 1;

    logic [SEL_W-1:0] sel;
    slot_t            pick;

    // oldest slot in the span with every operand resolved
    always_comb begin
        order = 1'b0;
        sel   = '0;
        for (int i = 0; i < ISSUE_SPAN; i++) begin
            if (!order && slots[i].valid && slots[i].rs1_ready
                    && slots[i].rs2_ready && slots[i].rd_ready) begin
                order = 1'b1;
                sel   = SEL_W'(i);
            end
        end
    end

    assign pick = slots[sel];

    always_comb begin
        issue.exec    = pick.exec;
        issue.func3   = pick.func3;
        issue.func7   = pick.func7;
        issue.d_rs1   = pick.d_rs1;
        issue.d_rs2   = pick.d_rs2;
        issue.pa_rd   = pick.pa_rd;
        issue.ctx     = pick.ctx;
        issue.b_t_ctx = pick.b_t_ctx;
        issue.b_f_ctx = pick.b_f_ctx;
    end

    // drop the slot once the execute stage has taken it
    always_comb begin
        for (int i = 0; i < WIN_SIZE; i++) begin
            kept_slots[i] = slots[i];
            if (order && accepted && (i < ISSUE_SPAN) && (sel == SEL_W'(i))) begin
                kept_slots[i].valid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/iw_pkg.sv
`default_nettype none

package iw_pkg;

    import isa_pkg::*;

    typedef logic [4:0] vreg_t;
    typedef logic [5:0] preg_t;
    typedef logic [3:0] ctx_t;

    // decoder output
    typedef struct packed {
        exec_t  exec;
        func3_t func3;
        func7_t func7;
        logic   rs1_req;
        vreg_t  va_rs1;
        logic   rs2_req;
        vreg_t  va_rs2;
        logic   rd_req;
        vreg_t  va_rd;
        word_t  imm;
        ctx_t   ctx;
        ctx_t   b_t_ctx;
        ctx_t   b_f_ctx;
    } dec_info_t;

    // one window entry
    typedef struct packed {
        logic   valid;
        exec_t  exec;
        func3_t func3;
        func7_t func7;
        word_t  imm;
        vreg_t  va_rs1;
        vreg_t  va_rs2;
        vreg_t  va_rd;
        logic   rs1_ready;
        logic   rs2_ready;
        logic   rd_ready;
        word_t  d_rs1;
        word_t  d_rs2;
        preg_t  pa_rd;
        ctx_t   ctx;
        ctx_t   b_t_ctx;
        ctx_t   b_f_ctx;
    } slot_t;

    // request to the register manager, one bit per unresolved operand
    typedef struct packed {
        logic  rs1_req;
        logic  rs2_req;
        logic  rd_req;
        vreg_t va_rs1;
        vreg_t va_rs2;
        vreg_t va_rd;
        ctx_t  ctx;
    } reg_lookup_t;

    typedef struct packed {
        logic  rs1_ready;
        word_t rs1_data;
        logic  rs2_ready;
        word_t rs2_data;
        logic  rd_ready;
        preg_t pa_rd;
    } reg_reply_t;

    // fields handed to the execute stage
    typedef struct packed {
        exec_t  exec;
        func3_t func3;
        func7_t func7;
        word_t  d_rs1;
        word_t  d_rs2;
        preg_t  pa_rd;
        ctx_t   ctx;
        ctx_t   b_t_ctx;
        ctx_t   b_f_ctx;
    } issue_t;

endpackage

`default_nettype wire

// File: design/operand_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module operand_resolve
    import isa_pkg::*;
    import iw_pkg::*;
#(
    parameter int WIN_SIZE = 8
) (
    input  slot_t       slots        [WIN_SIZE],
    input  slot_t       packed_slots [WIN_SIZE],
    input  logic        reply_valid,
    input  reg_reply_t  reply,
    input  logic        branch_hazard,
    input  ctx_t        hazard_ctx,
    output logic        lookup_valid,
    output reg_lookup_t lookup,
    output slot_t       next_slots   [WIN_SIZE]
);

    slot_t head;
    logic  addr_calc;

    // request from the registered head so it is a stable level
    always_comb begin
        lookup.rs1_req = slots[0].valid & ~slots[0].rs1_ready;
        lookup.rs2_req = slots[0].valid & ~slots[0].rs2_ready;
        lookup.rd_req  = slots[0].valid & ~slots[0].rd_ready;
        lookup.va_rs1  = slots[0].va_rs1;
        lookup.va_rs2  = slots[0].va_rs2;
        lookup.va_rd   = slots[0].va_rd;
        lookup.ctx     = slots[0].ctx;
    end

    assign lookup_valid = lookup.rs1_req | lookup.rs2_req | lookup.rd_req;

    // mem and jump take rs1 plus imm
    assign addr_calc = packed_slots[0].exec[EXEC_MEM] | packed_slots[0].exec[EXEC_JUMP];

    // head is the same entry in both arrays while a lookup is open
    always_comb begin
        head = packed_slots[0];
        if (reply_valid && lookup_valid) begin
            if (reply.rs1_ready && lookup.rs1_req) begin
                head.rs1_ready = 1'b1;
                head.d_rs1     = addr_calc ? reply.rs1_data + head.imm : reply.rs1_data;
            end
            if (reply.rs2_ready && lookup.rs2_req) begin
                head.rs2_ready = 1'b1;
                head.d_rs2     = reply.rs2_data;
            end
            if (reply.rd_ready && lookup.rd_req) begin
                head.rd_ready = 1'b1;
                head.pa_rd    = reply.pa_rd;
            end
        end
    end

    // squash everything on the mispredicted path
    always_comb begin
        for (int i = 0; i < WIN_SIZE; i++) begin
            next_slots[i] = (i == 0) ? head : packed_slots[i];
            if (branch_hazard && |(next_slots[i].ctx & hazard_ctx)) begin
                next_slots[i].valid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/window_compact.sv
`timescale 1ns/1ps
`default_nettype none

module window_compact
    import iw_pkg::*;
#(
    parameter int WIN_SIZE = 8
) (
    input  slot_t kept_slots   [WIN_SIZE],
    output slot_t packed_slots [WIN_SIZE],
    output logic  accept_able
);

    localparam int CNT_W = $clog2(WIN_SIZE + 1);

    // number of valid slots below each position
    logic [CNT_W-1:0] below [WIN_SIZE];

    always_comb begin
        below[0] = '0;
        for (int i = 1; i < WIN_SIZE; i++) begin
            below[i] = below[i-1] + CNT_W'(kept_slots[i-1].valid);
        end
    end

    // each valid slot lands at its prefix count, so age order holds
    always_comb begin
        for (int j = 0; j < WIN_SIZE; j++) begin
            packed_slots[j]       = kept_slots[j];
            packed_slots[j].valid = 1'b0;
            // a slot only ever moves down, so sources start at j
            for (int i = j; i < WIN_SIZE; i++) begin
                if (kept_slots[i].valid && (below[i] == CNT_W'(j))) begin
                    packed_slots[j] = kept_slots[i];
                end
            end
        end
    end

    // room for one more entry when the tail stays empty
    assign accept_able = ~packed_slots[WIN_SIZE-1].valid;

endmodule

`default_nettype wire

// File: design/window_slots.sv
`timescale 1ns/1ps
`default_nettype none

module window_slots
    import iw_pkg::*;
#(
    parameter int WIN_SIZE = 8
) (
    input  logic  clk,
    input  logic  rst_n,
    input  slot_t next_slots [WIN_SIZE],
    input  slot_t entry,
    input  logic  d_done,
    input  logic  accept_able,
    output slot_t slots      [WIN_SIZE]
);

    localparam int TAIL = WIN_SIZE - 1;

    logic              take;
    logic [WIN_SIZE-1:0] valid_q;
    slot_t             data_q [WIN_SIZE];

    // decoder handshake
    assign take = d_done & accept_able;

    // valid bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < TAIL; i++) begin
                valid_q[i] <= next_slots[i].valid;
            end
            if (take) begin
                valid_q[TAIL] <= entry.valid;
            end else begin
                valid_q[TAIL] <= next_slots[TAIL].valid;
            end
        end
    end

    // slot payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < TAIL; i++) begin
            data_q[i] <= next_slots[i];
        end
        if (take) begin
            data_q[TAIL] <= entry;
        end else begin
            data_q[TAIL] <= next_slots[TAIL];
        end
    end

    always_comb begin
        for (int i = 0; i < WIN_SIZE; i++) begin
            slots[i]       = data_q[i];
            slots[i].valid = valid_q[i];
        end
    end

endmodule

`default_nettype wire

// File: list.f
design/isa_pkg.sv
design/iw_pkg.sv
design/dispatch_unpack.sv
design/window_slots.sv
design/issue_select.sv
design/window_compact.sv
design/operand_resolve.sv
design/inst_window.sv
sim/inst_window_sva.sv
sim/tb_inst_window.sv

// File: sim/inst_window_sva.sv
`timescale 1ns/1ps
`default_nettype none

module inst_window_sva
    import iw_pkg::*;
(
    input wire logic   clk,
    input wire logic   rst_n,
    input wire logic   accept_able,
    input wire logic   lookup_valid,
    input wire logic   reply_valid,
    input wire logic   order,
    input wire issue_t issue,
    input wire logic   accepted,
    input wire logic   branch_hazard
);

    // first cycle out of reset sees an empty window
    assert property (@(posedge clk) $rose(rst_n) |-> !order && !lookup_valid && accept_able)
        else $error("window not empty after reset");

    // stalled issue holds, unless a kill or a head reply changes the pick
    assert property (@(posedge clk) disable iff (!rst_n)
        order && !accepted && !branch_hazard && !reply_valid |=> order && $stable(issue))
        else $error("issue changed under back-pressure");

    assert property (@(posedge clk) disable iff (!rst_n) reply_valid |-> lookup_valid)
        else $error("register reply without an open lookup");

    // an issued slot is never an empty decode
    assert property (@(posedge clk) disable iff (!rst_n) order |-> issue.exec != '0)
        else $error("issue with zero exec");

endmodule

bind inst_window inst_window_sva inst_window_sva_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .accept_able   (accept_able),
    .lookup_valid  (lookup_valid),
    .reply_valid   (reply_valid),
    .order         (order),
    .issue         (issue),
    .accepted      (accepted),
    .branch_hazard (branch_hazard)
);

`default_nettype wire

// File: sim/tb_inst_window.sv
`timescale 1ns/1ps
`default_nettype none

module tb_inst_window
    import isa_pkg::*;
    import iw_pkg::*;
();

    localparam int WIN_SIZE   = 8;
    localparam int ISSUE_SPAN = 4;
    localparam ctx_t HAZ_CTX  = 4'b1000;

    logic        clk;
    logic        rst_n;
    logic        d_done;
    dec_info_t   d_info;
    logic        accept_able;
    logic        lookup_valid;
    reg_lookup_t lookup;
    logic        reply_valid;
    reg_reply_t  reply;
    logic        order;
    issue_t      issue;
    logic        accepted;
    logic        branch_hazard;
    ctx_t        hazard_ctx;

    logic [31:0] lfsr_state;
    issue_t      exp_issue [128];
    logic        known     [128];
    logic        issued    [128];
    logic        killed    [128];
    dec_info_t   cur;
    logic        have_cur;
    logic        aa_seen;
    logic        saw_bypass;
    int          next_tag;
    int          n_intake;
    int          issue_tag;
    int          delay_left;
    int          guard;

    inst_window #(.WIN_SIZE(WIN_SIZE), .ISSUE_SPAN(ISSUE_SPAN)) dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .d_done        (d_done),
        .d_info        (d_info),
        .accept_able   (accept_able),
        .lookup_valid  (lookup_valid),
        .lookup        (lookup),
        .reply_valid   (reply_valid),
        .reply         (reply),
        .order         (order),
        .issue         (issue),
        .accepted      (accepted),
        .branch_hazard (branch_hazard),
        .hazard_ctx    (hazard_ctx)
    );

    always #50 clk = ~clk;

    task automatic stop_on_error();
        $display("Finished with errors");
        $fatal(1);
    endtask

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // register file contents seen by the manager model
    function automatic word_t reg_val(input vreg_t a);
        return {27'd0, a} * 32'h0000_0101 + 32'd1;
    endfunction

    function automatic issue_t predict(input dec_info_t d);
        issue_t p;
        p         = '0;
        p.exec    = d.exec;
        p.func3   = d.func3;
        p.func7   = d.func7;
        p.ctx     = d.ctx;
        p.b_t_ctx = d.b_t_ctx;
        p.b_f_ctx = d.b_f_ctx;
        if (d.rs1_req) begin
            p.d_rs1 = reg_val(d.va_rs1);
            if (d.exec[EXEC_MEM] || d.exec[EXEC_JUMP]) begin
                p.d_rs1 = p.d_rs1 + d.imm;
            end
        end
        if (d.rs2_req) begin
            p.d_rs2 = reg_val(d.va_rs2);
        end else if (d.exec[EXEC_ALU_IMM]) begin
            p.d_rs2 = d.imm;
        end
        if (d.rd_req) begin
            p.pa_rd = {1'b0, d.va_rd} + 6'd32;
        end
        return p;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    // oldest instruction still in the window, 0 when there is none
    function automatic int oldest_pending();
        for (int t = 1; t < 128; t++) begin
            if (known[t] && !issued[t] && !killed[t]) begin
                return t;
            end
        end
        return 0;
    endfunction

    // register manager model, replies after 1 to 3 cycles
    task automatic serve_lookup();
        int head_tag;
        if (lookup_valid) begin
            head_tag = oldest_pending();
            assert (head_tag != 0) else begin
                $display("lookup open with no instruction in the window");
                stop_on_error();
            end
            check_field("lookup.ctx", 32'(lookup.ctx), 32'(exp_issue[head_tag].ctx));
        end
        if (reply_valid) begin
            reply_valid <= 1'b0;
            delay_left  = 0;
        end else if (lookup_valid && !branch_hazard) begin
            if (delay_left == 0) begin
                delay_left = 1 + int'(rand_bits(2) % 3);
            end
            delay_left--;
            if (delay_left == 0) begin
                reply_valid     <= 1'b1;
                reply.rs1_ready <= lookup.rs1_req;
                reply.rs1_data  <= reg_val(lookup.va_rs1);
                reply.rs2_ready <= lookup.rs2_req;
                reply.rs2_data  <= reg_val(lookup.va_rs2);
                reply.rd_ready  <= lookup.rd_req;
                reply.pa_rd     <= {1'b0, lookup.va_rd} + 6'd32;
            end
        end else begin
            delay_left = 0;
        end
    endtask

    // quiet entries request no registers
    task automatic build_inst(input ctx_t mask, input logic quiet);
        logic none;
        cur       = '0;
        cur.exec  = exec_t'(4'b0001 << rand_bits(2));
        if (!quiet && rand_bits(4) == 0) begin
            cur.exec = EXEC_NOP;
        end
        cur.func3 = func3_t'(rand_bits(3));
        cur.func7 = func7_t'(next_tag);
        none      = quiet || (rand_bits(2) == 0);
        cur.rs1_req = !none && (rand_bits(1) != 0);
        cur.rs2_req = !none && (rand_bits(1) != 0);
        cur.rd_req  = !none && (rand_bits(1) != 0);
        cur.va_rs1  = vreg_t'(rand_bits(5));
        cur.va_rs2  = vreg_t'(rand_bits(5));
        cur.va_rd   = vreg_t'(rand_bits(5));
        cur.imm     = rand_bits(32);
        cur.ctx     = ctx_t'(rand_bits(4)) & mask;
        cur.b_t_ctx = ctx_t'(rand_bits(4));
        cur.b_f_ctx = ctx_t'(rand_bits(4));
        next_tag++;
        have_cur = 1'b1;
    endtask

    // one clock: observe the edge, then drive the next cycle
    task automatic step(input logic send, input logic acc_on, input ctx_t mask,
                        input logic quiet, input logic hz);
        @(posedge clk);
        aa_seen = accept_able;
        if (d_done && accept_able) begin
            if (cur.exec != EXEC_NOP) begin
                known[cur.func7]     = 1'b1;
                exp_issue[cur.func7] = predict(cur);
                n_intake++;
            end
            have_cur = 1'b0;
        end
        serve_lookup();
        if (branch_hazard) begin
            for (int t = 0; t < 128; t++) begin
                if (known[t] && !issued[t] && (exp_issue[t].ctx & hazard_ctx) != '0) begin
                    killed[t] = 1'b1;
                end
            end
        end
        if (send && !have_cur && next_tag < 127) begin
            build_inst(mask, quiet);
        end
        d_done        <= have_cur;
        d_info        <= cur;
        accepted      <= acc_on && (rand_bits(1) != 0);
        branch_hazard <= hz;
        hazard_ctx    <= HAZ_CTX;
    endtask

    task automatic send_until(input int limit, input ctx_t mask);
        guard = 0;
        while (next_tag < limit) begin
            step(1'b1, 1'b1, mask, 1'b0, 1'b0);
            guard++;
            if (guard > 2000) begin
                $display("dispatch stalled before tag %0d", limit);
                stop_on_error();
            end
        end
    endtask

    function automatic int pending_count();
        int n;
        n = 0;
        for (int t = 0; t < 128; t++) begin
            if (known[t] && !issued[t] && !killed[t]) begin
                n++;
            end
        end
        return n;
    endfunction

    // scoreboard on each accepted issue
    always @(posedge clk) begin
        if (rst_n && order && accepted) begin
            issue_tag = int'(issue.func7);
            assert (known[issue_tag] && !issued[issue_tag] && !killed[issue_tag]) else begin
                $display("unexpected issue of tag %0d", issue_tag);
                stop_on_error();
            end
            check_field("issue.exec", 32'(issue.exec), 32'(exp_issue[issue_tag].exec));
            check_field("issue.func3", 32'(issue.func3), 32'(exp_issue[issue_tag].func3));
            check_field("issue.d_rs1", issue.d_rs1, exp_issue[issue_tag].d_rs1);
            check_field("issue.d_rs2", issue.d_rs2, exp_issue[issue_tag].d_rs2);
            check_field("issue.pa_rd", 32'(issue.pa_rd), 32'(exp_issue[issue_tag].pa_rd));
            check_field("issue.ctx", 32'(issue.ctx), 32'(exp_issue[issue_tag].ctx));
            check_field("issue.b_t_ctx", 32'(issue.b_t_ctx), 32'(exp_issue[issue_tag].b_t_ctx));
            check_field("issue.b_f_ctx", 32'(issue.b_f_ctx), 32'(exp_issue[issue_tag].b_f_ctx));
            issued[issue_tag] = 1'b1;
            // a younger entry got past a head still waiting on registers
            if (lookup_valid) begin
                saw_bypass = 1'b1;
            end
        end
    end

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        d_done        = 1'b0;
        d_info        = '0;
        reply_valid   = 1'b0;
        reply         = '0;
        accepted      = 1'b0;
        branch_hazard = 1'b0;
        hazard_ctx    = '0;
        lfsr_state    = 32'h8490ecec;
        cur           = '0;
        have_cur      = 1'b0;
        aa_seen       = 1'b1;
        saw_bypass    = 1'b0;
        next_tag      = 1;
        n_intake      = 0;
        delay_left    = 0;
        for (int t = 0; t < 128; t++) begin
            known[t]  = 1'b0;
            issued[t] = 1'b0;
            killed[t] = 1'b0;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // fill the window with nothing leaving
        guard = 0;
        while (aa_seen) begin
            step(1'b1, 1'b0, 4'hf, 1'b1, 1'b0);
            guard++;
            if (guard > 50) begin
                $display("window never reported full");
                stop_on_error();
            end
        end
        check_field("intake count", 32'(n_intake), 32'(WIN_SIZE));

        send_until(50, 4'hf);

        // settle the decoder, then squash one context
        guard = 0;
        while (have_cur) begin
            step(1'b0, 1'b1, 4'hf, 1'b0, 1'b0);
            guard++;
            if (guard > 100) begin
                $display("decoder entry never taken before hazard");
                stop_on_error();
            end
        end
        step(1'b0, 1'b0, 4'hf, 1'b0, 1'b1);
        step(1'b0, 1'b1, 4'h7, 1'b0, 1'b0);

        send_until(100, 4'h7);

        guard = 0;
        while (have_cur || pending_count() != 0) begin
            step(1'b0, 1'b1, 4'h7, 1'b0, 1'b0);
            guard++;
            if (guard > 1000) begin
                $display("%0d instructions never issued", pending_count());
                stop_on_error();
            end
        end

        if (!saw_bypass) begin
            $display("no younger entry issued past a pending lookup");
            stop_on_error();
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire
